//--- hdl/frame_timer.sv
`timescale 1ns/1ns
`include "music_player_params.svh"

module frame_timer #(
    parameter int beat_count = `BEAT_COUNT_DEFAULT
) (
    input  logic clk,
    input  logic arst_n,
    input  logic new_frame,
    output logic sample_strobe,
    output logic beat
);

    localparam int cnt_w = (beat_count > 1) ? $clog2(beat_count) : 1;

    logic [cnt_w-1:0] frame_cnt;
    logic             last_frame;

    // frame that closes the current beat
    assign last_frame = (frame_cnt == cnt_w'(beat_count - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample_strobe <= 1'b0;
            beat          <= 1'b0;
            frame_cnt     <= '0;
        end else begin
            // codec frame pulse delayed one cycle
            sample_strobe <= new_frame;
            // beat rides on the strobe of the last frame
            beat          <= new_frame && last_frame;
            if (new_frame) begin
                frame_cnt <= last_frame ? '0 : frame_cnt + 1'b1;
            end
        end
    end

    // beat never shows up between frames
    assert property (@(posedge clk) disable iff (!arst_n) beat |-> sample_strobe)
        else $error("beat without sample_strobe");

endmodule

//--- hdl/mcu.sv
`timescale 1ns/1ns
`include "music_player_params.svh"

module mcu (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       play_button,
    input  logic                       next_button,
    input  logic                       song_done,
    output logic                       play,
    output logic                       reset_player,
    output music_player_pkg::song_id_t song
);

    typedef enum logic {
        st_paused,
        st_playing
    } mcu_state_t;

    mcu_state_t state;
    mcu_state_t state_next;
    logic       restart;

    // next song and end of song both stop play and rewind the reader
    assign restart = next_button || song_done;

    always_comb begin
        state_next = state;
        if (restart) begin
            state_next = st_paused;
        end else if (play_button) begin
            // play button toggles between play and pause
            state_next = (state == st_playing) ? st_paused : st_playing;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= st_paused;
            reset_player <= 1'b0;
            song         <= '0;
        end else begin
            state        <= state_next;
            reset_player <= restart;
            // song index wraps after the last table entry
            if (next_button) begin
                song <= (song == music_player_pkg::song_id_t'(`SONG_COUNT - 1)) ?
                        '0 : song + 1'b1;
            end
        end
    end

    assign play = (state == st_playing);

    // next press and song end never land back to back
    assert property (@(posedge clk) disable iff (!arst_n) reset_player |=> !reset_player)
        else $error("reset_player high on two consecutive cycles");

endmodule

//--- hdl/music_player.sv
`timescale 1ns/1ns
`include "music_player_params.svh"

module music_player #(
    parameter int beat_count = `BEAT_COUNT_DEFAULT
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      play_button,
    input  logic                      next_button,
    input  logic                      new_frame,
    output logic                      new_sample_generated,
    output music_player_pkg::sample_t sample_total_out,
    output music_player_pkg::sample_t sample_one_out,
    output music_player_pkg::sample_t sample_two_out,
    output music_player_pkg::sample_t sample_three_out
);

    // control
    logic                       play;
    logic                       reset_player;
    logic                       song_done;
    music_player_pkg::song_id_t song;

    // chord path
    music_player_pkg::chord_t   chord;
    logic                       chord_load;
    logic [2:0]                 voice_idle;

    // frame timing
    logic                       sample_strobe;
    logic                       beat;

    mcu u_mcu (
        .clk          (clk),
        .arst_n       (arst_n),
        .play_button  (play_button),
        .next_button  (next_button),
        .song_done    (song_done),
        .play         (play),
        .reset_player (reset_player),
        .song         (song)
    );

    // reset_player stops here, the voices ring out untouched
    song_reader u_song_reader (
        .clk          (clk),
        .arst_n       (arst_n),
        .play         (play),
        .reset_player (reset_player),
        .beat         (beat),
        .song         (song),
        .voice_idle   (voice_idle),
        .chord        (chord),
        .chord_load   (chord_load),
        .song_done    (song_done)
    );

    frame_timer #(
        .beat_count (beat_count)
    ) u_frame_timer (
        .clk           (clk),
        .arst_n        (arst_n),
        .new_frame     (new_frame),
        .sample_strobe (sample_strobe),
        .beat          (beat)
    );

    note_voice u_voice_one (
        .clk           (clk),
        .arst_n        (arst_n),
        .play          (play),
        .chord_load    (chord_load),
        .beat          (beat),
        .sample_strobe (sample_strobe),
        .note          (chord.note_one),
        .duration      (chord.duration_one),
        .sample_out    (sample_one_out),
        .idle          (voice_idle[0])
    );

    note_voice u_voice_two (
        .clk           (clk),
        .arst_n        (arst_n),
        .play          (play),
        .chord_load    (chord_load),
        .beat          (beat),
        .sample_strobe (sample_strobe),
        .note          (chord.note_two),
        .duration      (chord.duration_two),
        .sample_out    (sample_two_out),
        .idle          (voice_idle[1])
    );

    note_voice u_voice_three (
        .clk           (clk),
        .arst_n        (arst_n),
        .play          (play),
        .chord_load    (chord_load),
        .beat          (beat),
        .sample_strobe (sample_strobe),
        .note          (chord.note_three),
        .duration      (chord.duration_three),
        .sample_out    (sample_three_out),
        .idle          (voice_idle[2])
    );

    voice_mixer u_voice_mixer (
        .clk           (clk),
        .arst_n        (arst_n),
        .sample_strobe (sample_strobe),
        .beat          (beat),
        .play          (play),
        .sample_one    (sample_one_out),
        .sample_two    (sample_two_out),
        .sample_three  (sample_three_out),
        .sample_total  (sample_total_out)
    );

    // a new sample is produced on every strobe
    assign new_sample_generated = sample_strobe;

endmodule

//--- hdl/music_player_params.svh
`ifndef MUSIC_PLAYER_PARAMS_SVH
`define MUSIC_PLAYER_PARAMS_SVH

// frames per beat at the 48 kHz codec rate
`define BEAT_COUNT_DEFAULT 1000

// phase added per frame for each unit of note code
`define PHASE_STEP_UNIT 64

// peak level of one square voice
`define VOICE_AMPLITUDE 16'h2000

// tremolo mutes one beat out of this many
`define TREMOLO_PERIOD 11

// song table size
`define SONG_COUNT 4
`define CHORDS_PER_SONG 4

`endif

//--- hdl/music_player_pkg.sv
package music_player_pkg;

    // pitch code, zero means rest
    typedef logic [5:0] note_code_t;

    // note length in beats
    typedef logic [5:0] duration_t;

    // signed codec sample
    typedef logic signed [15:0] sample_t;

    // index into the song table
    typedef logic [1:0] song_id_t;

    // voice phase accumulator, top bit picks the square half
    typedef logic [15:0] phase_t;

    // one chord row of the song table
    // three pitches first, then their lengths in the same voice order
    typedef struct packed {
        note_code_t note_one;
        note_code_t note_two;
        note_code_t note_three;
        duration_t  duration_one;
        duration_t  duration_two;
        duration_t  duration_three;
    } chord_t;

endpackage

//--- hdl/note_voice.sv
`timescale 1ns/1ns
`include "music_player_params.svh"

module note_voice (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         play,
    input  logic                         chord_load,
    input  logic                         beat,
    input  logic                         sample_strobe,
    input  music_player_pkg::note_code_t note,
    input  music_player_pkg::duration_t  duration,
    output music_player_pkg::sample_t    sample_out,
    output logic                         idle
);

    localparam music_player_pkg::sample_t amp_high = `VOICE_AMPLITUDE;
    localparam music_player_pkg::sample_t amp_low  = -amp_high;

    music_player_pkg::note_code_t note_q;
    music_player_pkg::duration_t  beats_left;
    music_player_pkg::phase_t     phase;
    music_player_pkg::phase_t     phase_step;
    music_player_pkg::phase_t     phase_next;
    logic                         advance;

    // done once the beat count runs out
    assign idle = (beats_left == '0);

    // one phase step per frame while sounding
    assign advance    = sample_strobe && play && !idle;
    assign phase_step = music_player_pkg::phase_t'(note_q) *
                        music_player_pkg::phase_t'(`PHASE_STEP_UNIT);
    assign phase_next = phase + phase_step;

    // pitch of the current note
    always_ff @(posedge clk) begin
        if (chord_load) begin
            note_q <= note;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beats_left <= '0;
            phase      <= '0;
            sample_out <= '0;
        end else begin
            // duration counts down only while playing
            if (chord_load) begin
                beats_left <= duration;
            end else if (play && beat && !idle) begin
                beats_left <= beats_left - 1'b1;
            end

            // restart the wave at each new note
            if (chord_load) begin
                phase <= '0;
            end else if (advance) begin
                phase <= phase_next;
            end

            // sample holds while paused
            if (sample_strobe && play) begin
                if (!advance || note_q == '0) begin
                    // rest or finished note
                    sample_out <= '0;
                end else begin
                    sample_out <= phase_next[15] ? amp_low : amp_high;
                end
            end
        end
    end

endmodule

//--- hdl/song_reader.sv
`timescale 1ns/1ns
`include "music_player_params.svh"

module song_reader (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       play,
    input  logic                       reset_player,
    input  logic                       beat,
    input  music_player_pkg::song_id_t song,
    input  logic [2:0]                 voice_idle,
    output music_player_pkg::chord_t   chord,
    output logic                       chord_load,
    output logic                       song_done
);

    localparam int idx_w = $clog2(`CHORDS_PER_SONG);

    // wait: no chord issued yet, run: a chord is sounding
    typedef enum logic {
        st_wait,
        st_run
    } reader_state_t;

    reader_state_t    state;
    logic [idx_w-1:0] chord_idx;
    logic             step;

    // voices all done, hold off while a load or song end is in flight
    assign step = play && (&voice_idle) && !chord_load && !song_done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_wait;
            chord_idx  <= '0;
            chord_load <= 1'b0;
            song_done  <= 1'b0;
        end else begin
            chord_load <= 1'b0;
            song_done  <= 1'b0;
            if (reset_player) begin
                // rewind only, voices keep ringing out
                state     <= st_wait;
                chord_idx <= '0;
            end else if (step) begin
                if (state == st_wait) begin
                    chord_load <= 1'b1;
                    state      <= st_run;
                end else if (chord_idx == idx_w'(`CHORDS_PER_SONG - 1)) begin
                    // last chord finished
                    chord_idx <= '0;
                    state     <= st_wait;
                    song_done <= 1'b1;
                end else begin
                    // next chord goes out on the same edge as the index
                    chord_idx  <= chord_idx + 1'b1;
                    chord_load <= 1'b1;
                end
            end
        end
    end

    // song table, notes then durations in beats
    always_comb begin
        case ({song, chord_idx})
            4'h0: chord = '{6'd40, 6'd48, 6'd55, 6'd4, 6'd4, 6'd4};
            4'h1: chord = '{6'd43, 6'd0, 6'd50, 6'd3, 6'd2, 6'd3};
            4'h2: chord = '{6'd45, 6'd52, 6'd60, 6'd2, 6'd4, 6'd2};
            4'h3: chord = '{6'd40, 6'd47, 6'd55, 6'd5, 6'd5, 6'd5};
            4'h4: chord = '{6'd36, 6'd44, 6'd51, 6'd3, 6'd3, 6'd3};
            4'h5: chord = '{6'd38, 6'd46, 6'd0, 6'd2, 6'd2, 6'd1};
            4'h6: chord = '{6'd41, 6'd49, 6'd56, 6'd4, 6'd2, 6'd2};
            4'h7: chord = '{6'd36, 6'd43, 6'd63, 6'd6, 6'd6, 6'd3};
            4'h8: chord = '{6'd50, 6'd57, 6'd62, 6'd2, 6'd2, 6'd2};
            4'h9: chord = '{6'd0, 6'd53, 6'd58, 6'd1, 6'd3, 6'd3};
            4'ha: chord = '{6'd48, 6'd55, 6'd61, 6'd4, 6'd4, 6'd2};
            4'hb: chord = '{6'd46, 6'd53, 6'd59, 6'd3, 6'd5, 6'd5};
            4'hc: chord = '{6'd33, 6'd40, 6'd47, 6'd2, 6'd3, 6'd4};
            4'hd: chord = '{6'd35, 6'd42, 6'd49, 6'd2, 6'd2, 6'd2};
            4'he: chord = '{6'd37, 6'd0, 6'd0, 6'd3, 6'd1, 6'd1};
            4'hf: chord = '{6'd32, 6'd39, 6'd44, 6'd5, 6'd4, 6'd3};
            default: chord = '0;
        endcase
    end

    // a load only goes out when every voice has finished its note
    assert property (@(posedge clk) disable iff (!arst_n) chord_load |-> &voice_idle)
        else $error("chord_load while a voice is busy");

    // durations must not lose a beat on the load edge
    assert property (@(posedge clk) disable iff (!arst_n) chord_load |-> !beat)
        else $error("chord_load coincides with beat");

endmodule

//--- hdl/voice_mixer.sv
`timescale 1ns/1ns
`include "music_player_params.svh"

module voice_mixer (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      sample_strobe,
    input  logic                      beat,
    input  logic                      play,
    input  music_player_pkg::sample_t sample_one,
    input  music_player_pkg::sample_t sample_two,
    input  music_player_pkg::sample_t sample_three,
    output music_player_pkg::sample_t sample_total
);

    localparam int trem_w = $clog2(`TREMOLO_PERIOD);

    logic [trem_w-1:0]         trem_cnt;
    logic [trem_w-1:0]         trem_next;
    logic                      mute;
    music_player_pkg::sample_t mix;

    // quarter level per voice so three full voices cannot overflow
    assign mix = (sample_one >>> 2) + (sample_two >>> 2) + (sample_three >>> 2);

    // tremolo position moves on beats while playing
    always_comb begin
        trem_next = trem_cnt;
        if (beat && play) begin
            trem_next = (trem_cnt == trem_w'(`TREMOLO_PERIOD - 1)) ?
                        '0 : trem_cnt + 1'b1;
        end
    end

    // silent from the beat that wraps the count until the following beat
    assign mute = (trem_next == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            trem_cnt     <= '0;
            sample_total <= '0;
        end else begin
            trem_cnt <= trem_next;
            // output steps once per frame, one frame behind the voices
            if (sample_strobe) begin
                sample_total <= mute ? '0 : mix;
            end
        end
    end

endmodule

//--- music_player.f
+incdir+hdl
hdl/music_player_pkg.sv
hdl/mcu.sv
hdl/song_reader.sv
hdl/note_voice.sv
hdl/frame_timer.sv
hdl/voice_mixer.sv
hdl/music_player.sv
verif/tb_clock_gen.sv
verif/music_player_checker.sv
verif/music_player_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f music_player.f \
    --top-module music_player_tb -Mdir obj_dir -o music_player_sim || exit 1
sim_out="$(./obj_dir/music_player_sim)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qF '** PASS **' && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

//--- verif/music_player_checker.sv
`timescale 1ns/1ns
`include "music_player_params.svh"

module music_player_checker #(
    parameter int beat_count = 4
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       play_button,
    input  logic                       next_button,
    input  logic                       new_frame,
    input  logic                       new_sample_generated,
    input  music_player_pkg::sample_t  sample_total_out,
    input  music_player_pkg::sample_t  sample_one_out,
    input  music_player_pkg::sample_t  sample_two_out,
    input  music_player_pkg::sample_t  sample_three_out,
    input  music_player_pkg::song_id_t dut_song,
    input  logic                       step_done,
    input  int                         step_idx,
    input  music_player_pkg::song_id_t exp_song,
    input  logic                       run_done,
    output int                         error_count
);

    localparam music_player_pkg::sample_t amp = `VOICE_AMPLITUDE;

    // reference state of one voice
    typedef struct packed {
        music_player_pkg::note_code_t note;
        music_player_pkg::duration_t  left;
        music_player_pkg::phase_t     phase;
        music_player_pkg::sample_t    smp;
    } voice_model_t;

    // model state, always the value after the latest rising edge
    voice_model_t              vm [3];
    logic                      m_play;
    logic                      m_rst;
    logic                      m_wait;
    logic                      m_load;
    logic                      m_done;
    logic                      m_strobe;
    logic                      m_beat;
    int                        m_song;
    int                        m_idx;
    int                        m_trem;
    int                        m_fcnt;
    music_player_pkg::sample_t m_total;

    int checks = 0;
    int errors = 0;
    int step_checks = 0;
    int step_errors = 0;

    assign error_count = errors;

    // reference song table, notes then beats per voice
    function automatic music_player_pkg::chord_t song_chord(input int song, input int idx);
        case (song * `CHORDS_PER_SONG + idx)
            0:  song_chord = {6'd40, 6'd48, 6'd55, 6'd4, 6'd4, 6'd4};
            1:  song_chord = {6'd43, 6'd0,  6'd50, 6'd3, 6'd2, 6'd3};
            2:  song_chord = {6'd45, 6'd52, 6'd60, 6'd2, 6'd4, 6'd2};
            3:  song_chord = {6'd40, 6'd47, 6'd55, 6'd5, 6'd5, 6'd5};
            4:  song_chord = {6'd36, 6'd44, 6'd51, 6'd3, 6'd3, 6'd3};
            5:  song_chord = {6'd38, 6'd46, 6'd0,  6'd2, 6'd2, 6'd1};
            6:  song_chord = {6'd41, 6'd49, 6'd56, 6'd4, 6'd2, 6'd2};
            7:  song_chord = {6'd36, 6'd43, 6'd63, 6'd6, 6'd6, 6'd3};
            8:  song_chord = {6'd50, 6'd57, 6'd62, 6'd2, 6'd2, 6'd2};
            9:  song_chord = {6'd0,  6'd53, 6'd58, 6'd1, 6'd3, 6'd3};
            10: song_chord = {6'd48, 6'd55, 6'd61, 6'd4, 6'd4, 6'd2};
            11: song_chord = {6'd46, 6'd53, 6'd59, 6'd3, 6'd5, 6'd5};
            12: song_chord = {6'd33, 6'd40, 6'd47, 6'd2, 6'd3, 6'd4};
            13: song_chord = {6'd35, 6'd42, 6'd49, 6'd2, 6'd2, 6'd2};
            14: song_chord = {6'd37, 6'd0,  6'd0,  6'd3, 6'd1, 6'd1};
            15: song_chord = {6'd32, 6'd39, 6'd44, 6'd5, 6'd4, 6'd3};
            default: song_chord = '0;
        endcase
    endfunction

    // quarter level, rounds toward minus infinity
    function automatic music_player_pkg::sample_t quarter(input music_player_pkg::sample_t s);
        quarter = s >>> 2;
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("FAILED %s exp %h got %h at %0t ns", name, exp, got, $time);
        end
    endtask

    // outputs are settled at the falling edge, inputs hold what the next edge sees
    always @(negedge clk) begin : model_step
        music_player_pkg::chord_t     ch;
        music_player_pkg::note_code_t ch_note [3];
        music_player_pkg::duration_t  ch_dur [3];
        music_player_pkg::phase_t     ph;
        music_player_pkg::sample_t    mix;
        logic                         all_idle;
        logic                         step_ok;
        logic                         restart;
        int                           trem_next;
        int                           v;
        if (!arst_n) begin
            for (v = 0; v < 3; v++) begin
                vm[v] = '0;
            end
            m_play   = 1'b0;
            m_rst    = 1'b0;
            m_wait   = 1'b1;
            m_load   = 1'b0;
            m_done   = 1'b0;
            m_strobe = 1'b0;
            m_beat   = 1'b0;
            m_song   = 0;
            m_idx    = 0;
            m_trem   = 0;
            m_fcnt   = 0;
            m_total  = '0;
        end else begin
            check_value("new_sample_generated", 16'(m_strobe), 16'(new_sample_generated));
            check_value("sample_one_out", vm[0].smp, sample_one_out);
            check_value("sample_two_out", vm[1].smp, sample_two_out);
            check_value("sample_three_out", vm[2].smp, sample_three_out);
            check_value("sample_total_out", m_total, sample_total_out);

            // everything below is taken from the state before the edge
            ch       = song_chord(m_song, m_idx);
            ch_note  = '{ch.note_one, ch.note_two, ch.note_three};
            ch_dur   = '{ch.duration_one, ch.duration_two, ch.duration_three};
            all_idle = (vm[0].left == 0) && (vm[1].left == 0) && (vm[2].left == 0);
            step_ok  = m_play && all_idle && !m_load && !m_done;
            restart  = next_button || m_done;

            // tremolo count wraps on a beat and that beat interval is silent
            trem_next = (m_beat && m_play) ? (m_trem + 1) % `TREMOLO_PERIOD : m_trem;
            mix = quarter(vm[0].smp) + quarter(vm[1].smp) + quarter(vm[2].smp);
            if (m_strobe) begin
                m_total = (trem_next == 0) ? 16'sd0 : mix;
            end
            m_trem = trem_next;

            // voices, sample from the advanced phase
            for (v = 0; v < 3; v++) begin
                ph = vm[v].phase + 16'(vm[v].note) * 16'(`PHASE_STEP_UNIT);
                if (m_strobe && m_play) begin
                    if (vm[v].left == 0 || vm[v].note == 0) begin
                        vm[v].smp = '0;
                    end else begin
                        vm[v].smp = ph[15] ? -amp : amp;
                    end
                    if (vm[v].left != 0) begin
                        vm[v].phase = ph;
                    end
                end
                if (m_play && m_beat && vm[v].left != 0) begin
                    vm[v].left = vm[v].left - 1'b1;
                end
                if (m_load) begin
                    vm[v].note  = ch_note[v];
                    vm[v].left  = ch_dur[v];
                    vm[v].phase = '0;
                end
            end

            // chord sequencing
            m_load = 1'b0;
            m_done = 1'b0;
            if (m_rst) begin
                m_wait = 1'b1;
                m_idx  = 0;
            end else if (step_ok) begin
                if (m_wait) begin
                    m_load = 1'b1;
                    m_wait = 1'b0;
                end else if (m_idx == `CHORDS_PER_SONG - 1) begin
                    m_idx  = 0;
                    m_wait = 1'b1;
                    m_done = 1'b1;
                end else begin
                    m_idx++;
                    m_load = 1'b1;
                end
            end

            // buttons and song end
            if (restart) begin
                m_play = 1'b0;
            end else if (play_button) begin
                m_play = !m_play;
            end
            if (next_button) begin
                m_song = (m_song + 1) % `SONG_COUNT;
            end
            m_rst = restart;

            // frame strobe and beat
            m_beat = new_frame && (m_fcnt == beat_count - 1);
            if (new_frame) begin
                m_fcnt = (m_fcnt + 1) % beat_count;
            end
            m_strobe = new_frame;

            if (step_done) begin
                check_value("song", 16'(exp_song), 16'(dut_song));
                $display("step %0d song %0d: %0d checks, %0d mismatches",
                         step_idx, exp_song, checks - step_checks, errors - step_errors);
                step_checks = checks;
                step_errors = errors;
            end
            if (run_done) begin
                $display("total: %0d checks, %0d mismatches", checks, errors);
            end
        end
    end

endmodule

//--- verif/music_player_tb.sv
`timescale 1ns/1ns

module music_player_tb;

    localparam int beat_count = 4;
    localparam int step_count = 11;

    // button action of a table row
    localparam logic [1:0] act_none = 2'd0;
    localparam logic [1:0] act_play = 2'd1;
    localparam logic [1:0] act_next = 2'd2;

    // press and frame count of a row with the song expected at its end
    typedef struct packed {
        logic [1:0] action;
        logic [7:0] frames;
        logic [1:0] song;
    } step_t;

    logic                       clk;
    logic                       arst_n;
    logic                       play_button;
    logic                       next_button;
    logic                       new_frame = 1'b0;
    logic                       new_sample_generated;
    music_player_pkg::sample_t  sample_total_out;
    music_player_pkg::sample_t  sample_one_out;
    music_player_pkg::sample_t  sample_two_out;
    music_player_pkg::sample_t  sample_three_out;
    logic                       step_done;
    int                         step_idx;
    music_player_pkg::song_id_t exp_song;
    logic                       run_done;
    int                         error_count;
    logic [2:0]                 frame_div = '0;
    step_t                      steps [step_count];
    bit                         timed_out;
    int                         cycles;
    int                         extra;
    int                         i;

    tb_clock_gen #(.period(100), .reset_cycles(3)) u_clock_gen (.clk(clk), .arst_n(arst_n));

    music_player #(.beat_count(beat_count)) DUT (.*);

    music_player_checker #(.beat_count(beat_count)) u_checker (.*, .dut_song(DUT.song));

    // codec frame pulse on one cycle in eight
    always @(posedge clk) begin
        if (!arst_n) begin
            frame_div <= '0;
            new_frame <= 1'b0;
        end else begin
            frame_div <= frame_div + 1'b1;
            new_frame <= (frame_div == 3'd7);
        end
    end

    // one cycle button pulse
    // a none action just idles two cycles
    task automatic press_button(input logic [1:0] action);
        @(posedge clk);
        play_button <= (action == act_play);
        next_button <= (action == act_next);
        @(posedge clk);
        play_button <= 1'b0;
        next_button <= 1'b0;
    endtask

    // count strobes and give up well past eight cycles per frame
    task automatic run_frames(input int count, output bit late);
        int seen;
        int waited;
        seen = 0;
        waited = 0;
        while (seen < count && waited < count * 8 + 40) begin
            @(negedge clk);
            waited++;
            if (new_sample_generated) begin
                seen++;
            end
        end
        late = (seen < count);
    endtask

    // tell the checker a row is over
    task automatic end_step(input int idx, input logic [1:0] song);
        @(posedge clk);
        step_done <= 1'b1;
        step_idx  <= idx;
        exp_song  <= song;
        @(posedge clk);
        step_done <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'h2e53));
        play_button = 1'b0;
        next_button = 1'b0;
        step_done   = 1'b0;
        step_idx    = 0;
        exp_song    = '0;
        run_done    = 1'b0;
        timed_out   = 1'b0;

        // idle, play, pause and resume to song end before the song changes
        steps[0]  = '{act_none, 8'd6,  2'd0};
        steps[1]  = '{act_play, 8'd30, 2'd0};
        steps[2]  = '{act_play, 8'd10, 2'd0};
        steps[3]  = '{act_play, 8'd60, 2'd0};
        steps[4]  = '{act_next, 8'd6,  2'd1};
        steps[5]  = '{act_play, 8'd90, 2'd1};
        steps[6]  = '{act_next, 8'd4,  2'd2};
        steps[7]  = '{act_next, 8'd4,  2'd3};
        steps[8]  = '{act_play, 8'd40, 2'd3};
        // next while playing stops and wraps to the first song
        steps[9]  = '{act_next, 8'd4,  2'd0};
        steps[10] = '{act_play, 8'd20, 2'd0};

        cycles = 0;
        while (!arst_n && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!arst_n) begin
            $display("reset was never released");
            timed_out = 1'b1;
        end

        for (i = 0; i < step_count && !timed_out; i++) begin
            press_button(steps[i].action);
            extra = $urandom % 4;
            run_frames(int'(steps[i].frames) + extra, timed_out);
            if (timed_out) begin
                $display("timeout waiting for frame strobes in step %0d", i);
            end else begin
                end_step(i, steps[i].song);
            end
        end

        // error count is settled here, the checker only updates it on falling edges
        @(posedge clk);
        run_done <= 1'b1;
        @(posedge clk);
        run_done <= 1'b0;
        if (timed_out || error_count != 0) begin
            $display("** FAIL **");
        end else begin
            $display("** PASS **");
        end
        $finish;
    end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period       = 100,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic arst_n
);

    // free running clock, starts low
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // reset held low over the first rising edges
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule
